// ==== bench/layer_renderer_chk.sv ====
module layer_renderer_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     start_of_line,
    input layer_bus_pkg::bus_addr_t bus_addr,
    input logic                     bus_strobe,
    input logic                     bus_ack,
    input logic                     linebuf_wren,
    input logic                     line_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Address held for the whole strobe
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        bus_strobe |=> $stable(bus_addr)) else $error("bus_addr changed during a strobe");

    // One ack per strobe
    a_strobe_after_ack: assert property (@(posedge clk) disable iff (rst)
        bus_ack |=> !bus_strobe) else $error("bus_strobe high right after an ack");

    // End of line holds with no further writes until the next line starts
    a_no_write_when_done: assert property (@(posedge clk) disable iff (rst)
        line_done && !start_of_line |=> line_done && !linebuf_wren)
        else $error("linebuf_wren high or line_done dropped before the next line");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !bus_strobe && !linebuf_wren) else $error("Bus or line buffer active in reset");

endmodule

// ==== bench/layer_renderer_tb.sv ====
module layer_renderer_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    localparam int LINE_CYCLES = 2000;
    localparam int NUM_PERIODS = 12;
    localparam int WATCHDOG_NS = NUM_PERIODS * LINE_CYCLES * 20 + 10000;

    logic clk, rst, start_of_screen, start_of_line, regs_write, bus_strobe, bus_ack;
    logic [REGS_ADDR_W-1:0] regs_addr;
    logic [REGS_DATA_W-1:0] regs_wrdata;
    logic [REGS_DATA_W-1:0] regs_rddata;
    bus_addr_t              bus_addr;
    bus_data_t              bus_rddata;
    lb_idx_t                linebuf_wridx;
    pixel_t                 linebuf_wrdata;
    logic                   linebuf_wren;

    logic [7:0]  mem [0:262143];
    pixel_t      lb_data [0:1023];
    logic        lb_written [0:1023];
    int          ref_line, line_ctr, lines_checked;
    event        line_ready;

    // Expected configuration shadowed from the register writes
    logic [2:0]  sh_mode;
    logic        sh_enable;
    logic [1:0]  sh_map_w, sh_map_h;
    logic [15:0] sh_map_base, sh_tile_base;
    logic [11:0] sh_hscroll, sh_vscroll;

    layer_renderer i_layer_renderer (.*);

    bind layer_renderer layer_renderer_chk i_layer_renderer_chk (
        .clk(clk), .rst(rst), .start_of_line(start_of_line), .bus_addr(bus_addr),
        .bus_strobe(bus_strobe), .bus_ack(bus_ack), .linebuf_wren(linebuf_wren),
        .line_done(line_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic bus_data_t mem_word(input bus_addr_t a);
        return {mem[a + 18'd3], mem[a + 18'd2], mem[a + 18'd1], mem[a]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory model and line buffer capture
    ////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (bus_strobe) begin
                repeat ($urandom_range(1, 3) - 1) @(negedge clk);
                @(posedge clk);
                bus_ack    <= 1'b1;
                bus_rddata <= mem_word(bus_addr);
                @(posedge clk);
                bus_ack    <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (linebuf_wren) begin
            lb_data[linebuf_wridx]    = linebuf_wrdata;
            lb_written[linebuf_wridx] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] reg_expect(input int a);
        case (a)
            0:       return {sh_mode, 4'b0000, sh_enable};
            1:       return {4'b0000, sh_map_h, sh_map_w};
            2:       return sh_map_base[7:0];
            3:       return sh_map_base[15:8];
            4:       return sh_tile_base[7:0];
            5:       return sh_tile_base[15:8];
            6:       return sh_hscroll[7:0];
            7:       return {4'b0000, sh_hscroll[11:8]};
            8:       return sh_vscroll[7:0];
            9:       return {4'b0000, sh_vscroll[11:8]};
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] pixel_ref(input int line, input int x);
        logic [11:0] ls;
        int          sub, b, width, col, row, idx;
        bus_addr_t   taddr;
        bus_data_t   word;
        logic [15:0] entry;
        logic [7:0]  rbyte;
        logic [3:0]  nib;
        ls    = 12'(line + int'(sh_vscroll));
        sub   = x + int'(sh_hscroll[2:0]);
        b     = sub % 8;
        width = 32 << sh_map_w;
        col   = ((sub / 8 + int'(sh_hscroll[10:3])) % 256) % width;
        row   = int'(ls[10:3]) % (32 << sh_map_h);
        idx   = row * width + col;
        word  = mem_word({16'(int'(sh_map_base) + idx / 2), 2'b00});
        entry = (idx % 2 == 1) ? word[31:16] : word[15:0];
        if (sh_mode == 3'd3) begin
            taddr = 18'(int'({sh_tile_base, 2'b00}) + int'(entry[9:0]) * 32 + int'(ls[2:0]) * 4);
            word  = mem_word(taddr);
            rbyte = word[(b / 2) * 8 +: 8];
            nib   = (b % 2 == 0) ? rbyte[7:4] : rbyte[3:0];
            return (nib == 4'h0) ? 8'h00 : {entry[15:12], nib};
        end
        taddr = 18'(int'({sh_tile_base, 2'b00}) + int'(entry[7:0]) * 8 + int'(ls[2]) * 4);
        word  = mem_word(taddr);
        rbyte = word[int'(ls[1:0]) * 8 +: 8];
        return rbyte[7 - b] ? {4'h0, entry[11:8]} : {4'h0, entry[15:12]};
    endfunction

    // Compare process runs once per finished line
    initial begin
        forever begin
            @(line_ready);
            for (int x = 0; x < LINE_PIXELS; x++) begin
                if (!lb_written[x]) begin
                    report_failure($sformatf("Line buffer index %0d was never written", x));
                end
                check_value($sformatf("linebuf_wrdata[%0d]", x), 32'(lb_data[x]),
                            32'(pixel_ref(ref_line, x)));
            end
            lines_checked++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        regs_addr   <= a;
        regs_wrdata <= d;
        regs_write  <= 1'b1;
        @(posedge clk);
        regs_write  <= 1'b0;
        case (reg_addr_e'(a))
            CTRL0: begin
                sh_enable = d[0];
                if (d[7:5] == 3'd0 || d[7:5] == 3'd3) sh_mode = d[7:5];
            end
            CTRL1: begin
                sh_map_h = d[3:2];
                sh_map_w = d[1:0];
            end
            MAP_BASE_L:  sh_map_base[7:0]   = d;
            MAP_BASE_H:  sh_map_base[15:8]  = d;
            TILE_BASE_L: sh_tile_base[7:0]  = d;
            TILE_BASE_H: sh_tile_base[15:8] = d;
            HSCROLL_L:   sh_hscroll[7:0]    = d;
            HSCROLL_H:   sh_hscroll[11:8]   = d[3:0];
            VSCROLL_L:   sh_vscroll[7:0]    = d;
            VSCROLL_H:   sh_vscroll[11:8]   = d[3:0];
            default: begin
            end
        endcase
    endtask

    task automatic read_all_regs();
        for (int a = 0; a < 16; a++) begin
            @(posedge clk);
            regs_addr <= 4'(a);
            @(negedge clk);
            check_value($sformatf("regs_rddata[%0d]", a), 32'(regs_rddata), 32'(reg_expect(a)));
        end
    endtask

    task automatic config_layer(input logic [2:0] mode, input logic [1:0] mw, input logic [1:0] mh,
                                input logic [15:0] mb, input logic [15:0] tb,
                                input logic [11:0] hs, input logic [11:0] vs);
        write_reg(4'd0, {mode, 4'b0000, 1'b1});
        write_reg(4'd1, {4'b0000, mh, mw});
        write_reg(4'd2, mb[7:0]);
        write_reg(4'd3, mb[15:8]);
        write_reg(4'd4, tb[7:0]);
        write_reg(4'd5, tb[15:8]);
        write_reg(4'd6, hs[7:0]);
        write_reg(4'd7, {4'b0000, hs[11:8]});
        write_reg(4'd8, vs[7:0]);
        write_reg(4'd9, {4'b0000, vs[11:8]});
    endtask

    task automatic pulse_start_of_screen();
        @(posedge clk);
        start_of_screen <= 1'b1;
        @(posedge clk);
        start_of_screen <= 1'b0;
        line_ctr = 0;
    endtask

    task automatic render_line();
        int cycles;
        int target;
        for (int i = 0; i < 1024; i++) lb_written[i] = 1'b0;
        ref_line = line_ctr;
        line_ctr++;
        @(posedge clk);
        start_of_line <= 1'b1;
        @(posedge clk);
        start_of_line <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!i_layer_renderer.line_done) begin
            if (cycles >= LINE_CYCLES - 2) report_failure("Line did not finish within a line period");
            @(negedge clk);
            cycles++;
        end
        target = lines_checked + 1;
        -> line_ready;
        wait (lines_checked == target);
        repeat (LINE_CYCLES - cycles) @(posedge clk);
    endtask

    // Disabled layer must stay silent for a whole line period
    task automatic check_idle_line();
        @(posedge clk);
        start_of_line <= 1'b1;
        @(posedge clk);
        start_of_line <= 1'b0;
        line_ctr++;
        repeat (LINE_CYCLES - 1) begin
            @(negedge clk);
            if (bus_strobe || linebuf_wren) report_failure("Bus or line buffer active while disabled");
        end
    endtask

    initial begin
        void'($urandom(32'hf214251a));
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = '0;
        regs_wrdata     = '0;
        regs_write      = 1'b0;
        bus_ack         = 1'b0;
        bus_rddata      = '0;
        for (int i = 0; i < 262144; i++) mem[i] = 8'($urandom);
        {sh_mode, sh_enable, sh_map_w, sh_map_h} = '0;
        {sh_map_base, sh_hscroll, sh_vscroll} = '0;
        sh_tile_base  = TILE_BASE_RESET;
        line_ctr      = 0;
        lines_checked = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Register readback after reset and after random writes
        read_all_regs();
        repeat (3) begin
            for (int a = 0; a < 10; a++) write_reg(4'(a), 8'($urandom));
            read_all_regs();
        end

        // Mode 0 with no scroll on a 32x32 map
        config_layer(3'd0, 2'd0, 2'd0, 16'($urandom), 16'($urandom), 12'd0, 12'd0);
        pulse_start_of_screen();
        repeat (2) render_line();

        // Mode 3 palette offset
        config_layer(3'd3, 2'd0, 2'd0, 16'($urandom), 16'($urandom), 12'd0, 12'd0);
        repeat (2) render_line();

        // Random scroll and map sizes
        repeat (6) begin
            config_layer($urandom_range(0, 1) ? 3'd3 : 3'd0, 2'($urandom), 2'($urandom),
                         16'($urandom), 16'($urandom), 12'($urandom), 12'($urandom));
            render_line();
        end

        write_reg(4'd0, {sh_mode, 4'b0000, 1'b0});
        check_idle_line();

        // Line counter restart
        write_reg(4'd0, {sh_mode, 4'b0000, 1'b1});
        pulse_start_of_screen();
        render_line();

        $display("Test passed");
        $finish;
    end

endmodule

// ==== hdl/layer_bus_pkg.sv ====
package layer_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////////////////////////

    localparam int BUS_ADDR_W = 18;
    localparam int BUS_DATA_W = 32;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    ////////////////////////////////////////////////////////////
    // Line buffer
    ////////////////////////////////////////////////////////////

    localparam int LB_IDX_W    = 10;
    localparam int LINE_PIXELS = 640;
    localparam int TILE_PIXELS = 8;

    typedef logic [LB_IDX_W-1:0] lb_idx_t;
    typedef logic [7:0]          pixel_t;

    // One tile row handed from the fetcher to the pixel renderer
    typedef struct packed {
        bus_data_t   pixels;
        logic [7:0]  attr;
    } render_job_t;

endpackage

// ==== hdl/layer_cfg_pkg.sv ====
package layer_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Register port
    ////////////////////////////////////////////////////////////

    localparam int REGS_ADDR_W = 4;
    localparam int REGS_DATA_W = 8;

    localparam int SCROLL_W = 12;

    localparam logic [15:0] TILE_BASE_RESET = 16'h8000;

    typedef enum logic [REGS_ADDR_W-1:0] {
        CTRL0       = 4'd0,
        CTRL1       = 4'd1,
        MAP_BASE_L  = 4'd2,
        MAP_BASE_H  = 4'd3,
        TILE_BASE_L = 4'd4,
        TILE_BASE_H = 4'd5,
        HSCROLL_L   = 4'd6,
        HSCROLL_H   = 4'd7,
        VSCROLL_L   = 4'd8,
        VSCROLL_H   = 4'd9
    } reg_addr_e;

    ////////////////////////////////////////////////////////////
    // Layer configuration
    ////////////////////////////////////////////////////////////

    // Mode 0 is 1 bpp with fg/bg from the map attribute
    typedef enum logic [2:0] {
        MODE_1BPP_FGBG = 3'd0,
        MODE_4BPP      = 3'd3
    } layer_mode_e;

    // Map size in tiles
    typedef enum logic [1:0] {
        MAP_32  = 2'd0,
        MAP_64  = 2'd1,
        MAP_128 = 2'd2,
        MAP_256 = 2'd3
    } map_size_e;

    typedef struct packed {
        layer_mode_e         mode;
        logic                enable;
        map_size_e           map_width;
        map_size_e           map_height;
        logic [15:0]         map_base;
        logic [15:0]         tile_base;
        logic [SCROLL_W-1:0] hscroll;
        logic [SCROLL_W-1:0] vscroll;
    } layer_cfg_t;

endpackage

// ==== hdl/layer_regs.sv ====
module layer_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [layer_cfg_pkg::REGS_ADDR_W-1:0] regs_addr,
    input  logic [layer_cfg_pkg::REGS_DATA_W-1:0] regs_wrdata,
    input  logic                                  regs_write,
    output logic [layer_cfg_pkg::REGS_DATA_W-1:0] regs_rddata,
    output layer_cfg_pkg::layer_cfg_t             cfg
);
    import layer_cfg_pkg::*;

    // Readback, unused bits return 0
    always_comb begin
        case (reg_addr_e'(regs_addr))
            CTRL0:       regs_rddata = {cfg.mode, 4'b0000, cfg.enable};
            CTRL1:       regs_rddata = {4'b0000, cfg.map_height, cfg.map_width};
            MAP_BASE_L:  regs_rddata = cfg.map_base[7:0];
            MAP_BASE_H:  regs_rddata = cfg.map_base[15:8];
            TILE_BASE_L: regs_rddata = cfg.tile_base[7:0];
            TILE_BASE_H: regs_rddata = cfg.tile_base[15:8];
            HSCROLL_L:   regs_rddata = cfg.hscroll[7:0];
            HSCROLL_H:   regs_rddata = {4'b0000, cfg.hscroll[SCROLL_W-1:8]};
            VSCROLL_L:   regs_rddata = cfg.vscroll[7:0];
            VSCROLL_H:   regs_rddata = {4'b0000, cfg.vscroll[SCROLL_W-1:8]};
            default:     regs_rddata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg           <= '0;
            cfg.tile_base <= TILE_BASE_RESET;
        end else if (regs_write) begin
            case (reg_addr_e'(regs_addr))
                CTRL0: begin
                    cfg.enable <= regs_wrdata[0];
                    // Unsupported mode codes keep the current mode
                    if (regs_wrdata[7:5] == MODE_1BPP_FGBG || regs_wrdata[7:5] == MODE_4BPP) begin
                        cfg.mode <= layer_mode_e'(regs_wrdata[7:5]);
                    end
                end

                CTRL1: begin
                    cfg.map_height <= map_size_e'(regs_wrdata[3:2]);
                    cfg.map_width  <= map_size_e'(regs_wrdata[1:0]);
                end

                MAP_BASE_L:  cfg.map_base[7:0]           <= regs_wrdata;
                MAP_BASE_H:  cfg.map_base[15:8]          <= regs_wrdata;
                TILE_BASE_L: cfg.tile_base[7:0]          <= regs_wrdata;
                TILE_BASE_H: cfg.tile_base[15:8]         <= regs_wrdata;
                HSCROLL_L:   cfg.hscroll[7:0]            <= regs_wrdata;
                HSCROLL_H:   cfg.hscroll[SCROLL_W-1:8]   <= regs_wrdata[3:0];
                VSCROLL_L:   cfg.vscroll[7:0]            <= regs_wrdata;
                VSCROLL_H:   cfg.vscroll[SCROLL_W-1:8]   <= regs_wrdata[3:0];
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hdl/layer_renderer.sv ====
module layer_renderer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_of_screen,
    input  logic                                  start_of_line,

    input  logic [layer_cfg_pkg::REGS_ADDR_W-1:0] regs_addr,
    input  logic [layer_cfg_pkg::REGS_DATA_W-1:0] regs_wrdata,
    input  logic                                  regs_write,
    output logic [layer_cfg_pkg::REGS_DATA_W-1:0] regs_rddata,

    output layer_bus_pkg::bus_addr_t              bus_addr,
    output logic                                  bus_strobe,
    input  layer_bus_pkg::bus_data_t              bus_rddata,
    input  logic                                  bus_ack,

    output layer_bus_pkg::lb_idx_t                linebuf_wridx,
    output layer_bus_pkg::pixel_t                 linebuf_wrdata,
    output logic                                  linebuf_wren
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    layer_cfg_t  cfg;
    render_job_t job;
    logic        job_start;
    logic        job_busy;
    logic        line_done;

    layer_regs i_layer_regs (
        .clk         (clk),
        .rst         (rst),
        .regs_addr   (regs_addr),
        .regs_wrdata (regs_wrdata),
        .regs_write  (regs_write),
        .regs_rddata (regs_rddata),
        .cfg         (cfg)
    );

    // Fetches map entries and tile rows one tile ahead
    line_fetch i_line_fetch (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .bus_addr        (bus_addr),
        .bus_strobe      (bus_strobe),
        .bus_rddata      (bus_rddata),
        .bus_ack         (bus_ack),
        .job             (job),
        .job_start       (job_start),
        .job_busy        (job_busy),
        .line_done       (line_done)
    );

    pixel_render i_pixel_render (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .start_of_line  (start_of_line),
        .job            (job),
        .job_start      (job_start),
        .job_busy       (job_busy),
        .line_done      (line_done),
        .linebuf_wridx  (linebuf_wridx),
        .linebuf_wrdata (linebuf_wrdata),
        .linebuf_wren   (linebuf_wren)
    );

endmodule

// ==== hdl/line_fetch.sv ====
module line_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  layer_cfg_pkg::layer_cfg_t   cfg,
    input  logic                        start_of_screen,
    input  logic                        start_of_line,
    output layer_bus_pkg::bus_addr_t    bus_addr,
    output logic                        bus_strobe,
    input  layer_bus_pkg::bus_data_t    bus_rddata,
    input  logic                        bus_ack,
    output layer_bus_pkg::render_job_t  job,
    output logic                        job_start,
    input  logic                        job_busy,
    input  logic                        line_done
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_MAP,
        WAIT_MAP,
        FETCH_TILE,
        WAIT_TILE,
        HANDOFF
    } state_e;

    state_e              state;
    logic [SCROLL_W-1:0] line_cnt;
    logic [SCROLL_W-1:0] cur_line;
    logic [SCROLL_W-1:0] line_base;
    logic [SCROLL_W-1:0] scr_line;
    logic [7:0]          tile_cnt;
    logic [7:0]          map_row;
    logic [7:0]          map_col;
    logic [15:0]         map_idx;
    logic [15:0]         map_entry;
    logic [7:0]          row_byte;
    logic                bus_strobe_r;
    logic                handoff_go;
    bus_addr_t           map_addr;
    bus_addr_t           tile_addr;
    bus_data_t           map_word_r;
    render_job_t         next_job_r;

    ////////////////////////////////////////////////////////////
    // Map and tile addresses
    ////////////////////////////////////////////////////////////

    assign scr_line = cur_line + cfg.vscroll;
    assign map_col  = tile_cnt + cfg.hscroll[10:3];

    always_comb begin
        case (cfg.map_height)
            MAP_32:  map_row = {3'b0, scr_line[7:3]};
            MAP_64:  map_row = {2'b0, scr_line[8:3]};
            MAP_128: map_row = {1'b0, scr_line[9:3]};
            default: map_row = scr_line[10:3];
        endcase

        // Row times width plus column
        case (cfg.map_width)
            MAP_32:  map_idx = {3'b0, map_row, map_col[4:0]};
            MAP_64:  map_idx = {2'b0, map_row, map_col[5:0]};
            MAP_128: map_idx = {1'b0, map_row, map_col[6:0]};
            default: map_idx = {map_row, map_col};
        endcase
    end

    // Two entries per word, odd index in the high half
    assign map_addr  = {cfg.map_base + {1'b0, map_idx[15:1]}, 2'b00};
    assign map_entry = map_idx[0] ? map_word_r[31:16] : map_word_r[15:0];

    always_comb begin
        if (cfg.mode == MODE_4BPP) begin
            tile_addr = {cfg.tile_base, 2'b00} + {3'b0, map_entry[9:0], scr_line[2:0], 2'b00};
        end else begin
            tile_addr = {cfg.tile_base, 2'b00} + {7'b0, map_entry[7:0], scr_line[2], 2'b00};
        end
    end

    // 1 bpp rows are packed four to a word
    assign row_byte = bus_rddata[{scr_line[1:0], 3'b000} +: 8];

    assign bus_strobe = bus_strobe_r && !bus_ack;
    assign line_base  = start_of_screen ? '0 : line_cnt;
    assign handoff_go = state == HANDOFF && !line_done && !job_busy && !start_of_line;

    ////////////////////////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            bus_strobe_r <= 1'b0;
            job_start    <= 1'b0;
            line_cnt     <= '0;
            cur_line     <= '0;
            tile_cnt     <= '0;
        end else begin
            job_start <= 1'b0;

            case (state)
                FETCH_MAP: begin
                    bus_strobe_r <= 1'b1;
                    state        <= WAIT_MAP;
                end
                FETCH_TILE: begin
                    bus_strobe_r <= 1'b1;
                    state        <= WAIT_TILE;
                end
                WAIT_MAP, WAIT_TILE: begin
                    if (bus_ack) begin
                        bus_strobe_r <= 1'b0;
                        state        <= (state == WAIT_MAP) ? FETCH_TILE : HANDOFF;
                    end
                end
                HANDOFF: begin
                    if (line_done) begin
                        state <= IDLE;
                    end else if (handoff_go) begin
                        job_start <= 1'b1;
                        tile_cnt  <= tile_cnt + 8'd1;
                        // Odd entry was the last one in this map word
                        state     <= map_idx[0] ? FETCH_MAP : FETCH_TILE;
                    end
                end
                default: begin
                end
            endcase

            // A new line also aborts an unfinished one
            if (start_of_line) begin
                state        <= cfg.enable ? FETCH_MAP : IDLE;
                bus_strobe_r <= 1'b0;
                job_start    <= 1'b0;
                tile_cnt     <= '0;
                cur_line     <= line_base;
                line_cnt     <= line_base + 1'b1;
            end else if (start_of_screen) begin
                line_cnt <= '0;
            end
        end
    end

    // Address and data capture
    always_ff @(posedge clk) begin
        if (state == FETCH_MAP) begin
            bus_addr <= map_addr;
        end
        if (state == FETCH_TILE) begin
            bus_addr <= tile_addr;
        end
        if (state == WAIT_MAP && bus_ack) begin
            map_word_r <= bus_rddata;
        end
        if (state == WAIT_TILE && bus_ack) begin
            next_job_r.attr   <= map_entry[15:8];
            next_job_r.pixels <= (cfg.mode == MODE_4BPP) ? bus_rddata
                                                         : {{(BUS_DATA_W-8){1'b0}}, row_byte};
        end
        if (handoff_go) begin
            job <= next_job_r;
        end
    end

endmodule

// ==== hdl/pixel_render.sv ====
module pixel_render (
    input  logic                        clk,
    input  logic                        rst,
    input  layer_cfg_pkg::layer_cfg_t   cfg,
    input  logic                        start_of_line,
    input  layer_bus_pkg::render_job_t  job,
    input  logic                        job_start,
    output logic                        job_busy,
    output logic                        line_done,
    output layer_bus_pkg::lb_idx_t      linebuf_wridx,
    output layer_bus_pkg::pixel_t       linebuf_wrdata,
    output logic                        linebuf_wren
);
    import layer_cfg_pkg::*;
    import layer_bus_pkg::*;

    logic [$clog2(TILE_PIXELS)-1:0] pix_cnt;
    logic [$clog2(TILE_PIXELS)-1:0] pix_next;
    lb_idx_t                        lb_idx_r;
    lb_idx_t                        lb_idx_next;
    lb_idx_t                        lb_start;
    logic                           busy_r;
    logic                           busy_next;
    logic                           wren_next;
    logic                           idx_end;
    logic                           bit_1bpp;
    logic [3:0]                     nibble;
    pixel_t                         colour;

    ////////////////////////////////////////////////////////////
    // Pixel select and colour
    ////////////////////////////////////////////////////////////

    // MSB first in 1 bpp, high nibble first in 4 bpp
    assign bit_1bpp = job.pixels[TILE_PIXELS - 1 - pix_cnt];
    assign nibble   = job.pixels[{pix_cnt[2:1], ~pix_cnt[0], 2'b00} +: 4];

    always_comb begin
        if (cfg.mode == MODE_4BPP) begin
            // Nibble 0 stays transparent black
            colour = (nibble == 4'h0) ? 8'h00 : {job.attr[7:4], nibble};
        end else begin
            colour = bit_1bpp ? {4'h0, job.attr[3:0]} : {4'h0, job.attr[7:4]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Write sequencing
    ////////////////////////////////////////////////////////////

    // Sub-tile scroll moves the first pixels off the left edge
    assign lb_start = '0 - lb_idx_t'(cfg.hscroll[2:0]);
    assign idx_end  = lb_idx_r == lb_idx_t'(LINE_PIXELS);

    always_comb begin
        pix_next    = pix_cnt;
        busy_next   = busy_r;
        lb_idx_next = lb_idx_r;
        wren_next   = 1'b0;

        if (!idx_end && (busy_r || job_start)) begin
            wren_next   = 1'b1;
            lb_idx_next = lb_idx_r + 1'b1;
            pix_next    = pix_cnt + 1'b1;
            busy_next   = pix_cnt != ($bits(pix_cnt))'(TILE_PIXELS - 1);
        end

        if (start_of_line) begin
            pix_next    = '0;
            busy_next   = 1'b0;
            lb_idx_next = lb_start;
        end
    end

    assign job_busy  = busy_next;
    assign line_done = idx_end && !linebuf_wren;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_cnt      <= '0;
            busy_r       <= 1'b0;
            lb_idx_r     <= '0;
            linebuf_wren <= 1'b0;
        end else begin
            pix_cnt      <= pix_next;
            busy_r       <= busy_next;
            lb_idx_r     <= lb_idx_next;
            linebuf_wren <= wren_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wren_next) begin
            linebuf_wridx  <= lb_idx_r;
            linebuf_wrdata <= colour;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module layer_renderer_tb -o sim_tb
./obj_dir/sim_tb

// ==== verilog.f ====
hdl/layer_cfg_pkg.sv
hdl/layer_bus_pkg.sv
hdl/layer_regs.sv
hdl/line_fetch.sv
hdl/pixel_render.sv
hdl/layer_renderer.sv
bench/layer_renderer_chk.sv
bench/layer_renderer_tb.sv
